// ==== files.f ====
hdl/lsuPkg.sv
hdl/dtim.sv
hdl/lsuAddrStage.sv
hdl/storeFormat.sv
hdl/loadFormat.sv
hdl/reservation.sv
hdl/lsu.sv
tests/lsu_checker.sv
tests/tbLsu.sv

// ==== Makefile ====
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tbLsu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Test failed"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "No pass result in log"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tbLsu.sv ====
/*
  Load/store unit testbench
  Table of accesses with a reference model, applied through the E/M/W pipeline
*/

`timescale 1ns/1ps

module tbLsu;

  typedef struct {
    lsuPkg::xlenT    adr;
    lsuPkg::lsuCtrlT ctrl;
    lsuPkg::xlenT    data;
    lsuPkg::xlenT    expRead;       // ReadDataW once this row leaves W
    logic            readValid;     // Zero after a faulting load
    logic [3:0]      expFault;      // LoadMis, StoreMis, LoadAcc, StoreAcc
    logic            expSquash;
    int              stall;         // Extra stalled cycles on this row
  } rowT;

  logic clk = 1'b0;
  logic rst;
  logic StallM;
  logic StallW;
  lsuPkg::xlenT    IEUAdrE;
  lsuPkg::lsuCtrlT CtrlM;
  lsuPkg::xlenT    WriteDataM;
  lsuPkg::xlenT    IEUAdrM;
  logic LoadMisalignedFaultM;
  logic StoreAmoMisalignedFaultM;
  logic LoadAccessFaultM;
  logic StoreAmoAccessFaultM;
  lsuPkg::xlenT    ReadDataW;
  logic            SquashSCW;

  rowT          rows[$];
  lsuPkg::xlenT memModel [lsuPkg::DtimWords];  // Expected DTIM contents
  logic [31:0]  lfsrState = 32'd27;
  lsuPkg::xlenT lastRead = '0;                 // Matches reset value
  logic         lastValid = 1'b1;
  logic         resValid = 1'b0;
  logic [29:0]  resAdr;
  int           cycles = 0;
  int           cycleLimit = 1000;

  lsu i_lsu (.*);

  always #10 clk = ~clk;

  //////////////////////////////////////////
  // Failure, timeout and compare tasks
  //////////////////////////////////////////

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) failRun("Timeout, the test table did not finish in time");
  end

  task automatic wordCheck(input string name, input lsuPkg::xlenT got, input lsuPkg::xlenT exp);
    if (got !== exp) begin
      failRun($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic faultCheck(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      failRun($sformatf("MISMATCH faults got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic squashCheck(input logic got, input logic exp);
    if (got !== exp) begin
      failRun($sformatf("MISMATCH SquashSCW got 0x%h expected 0x%h", got, exp));
    end
  endtask

  //////////////////////////////////////////
  // Stimulus source and reference model
  //////////////////////////////////////////

  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);  // Galois taps 32,30,26,25
  endfunction

  function automatic lsuPkg::xlenT randomWord();
    lsuPkg::xlenT w;
    for (int b = 0; b < 32; b++) begin
      w[b] = lfsrState[0];          // One step per bit
      lfsrState = galoisStep(lfsrState);
    end
    return w;
  endfunction

  task automatic addRow(input lsuPkg::xlenT adr, input logic [1:0] rw, input logic [2:0] f3,
                        input logic [1:0] at, input logic be, input int stall);
    rowT r;
    int size;
    int lane;
    int pos;
    logic mis;
    logic inRange;
    logic ok;
    logic isSc;
    logic isLr;
    logic pass;
    lsuPkg::dtimAdrT idx;
    lsuPkg::xlenT val;
    r.adr = adr;
    r.ctrl.memRw = rw;
    r.ctrl.funct3 = f3;
    r.ctrl.atomic = at;
    r.ctrl.bigEndian = be;
    r.stall = stall;
    r.data = rw[0] ? randomWord() : '0;
    size = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
    mis = (adr[1:0] % size) != 0;
    inRange = (adr >= lsuPkg::DtimBase) && ((adr - lsuPkg::DtimBase) < 32'd1024);
    ok = inRange && !mis;
    idx = adr[9:2];
    r.expFault = {rw[1] & mis, rw[0] & mis,
                  rw[1] & ~mis & ~inRange, rw[0] & ~mis & ~inRange};
    isSc = rw[0] && (at == lsuPkg::AtomicSc);
    isLr = rw[1] && (at == lsuPkg::AtomicLr);
    pass = isSc && resValid && (resAdr == adr[31:2]);
    if (rw[0] && ok && (!isSc || pass)) begin
      for (int k = 0; k < size; k++) begin
        lane = adr[1:0] + k;
        pos = be ? (size - 1 - k) : k;  // Big endian puts the MSB at the lowest address
        memModel[idx][8*lane +: 8] = r.data[8*pos +: 8];
      end
    end
    if (rw[1]) begin
      if (ok) begin
        val = '0;
        for (int k = 0; k < size; k++) begin
          lane = adr[1:0] + k;
          pos = be ? (size - 1 - k) : k;
          val[8*pos +: 8] = memModel[idx][8*lane +: 8];
        end
        if (size == 1 && !f3[2]) val = {{24{val[7]}}, val[7:0]};
        if (size == 2 && !f3[2]) val = {{16{val[15]}}, val[15:0]};
        lastRead = val;
        lastValid = 1'b1;
      end else begin
        lastValid = 1'b0;           // Faulting load result is undefined
      end
    end
    if (isLr && ok) begin
      resValid = 1'b1;
      resAdr = adr[31:2];
    end else if (isSc) begin
      resValid = 1'b0;
    end
    r.expRead = lastRead;
    r.readValid = lastValid;
    r.expSquash = isSc && !pass;
    rows.push_back(r);
  endtask

  task automatic idle(input int stall);
    addRow('0, 2'b00, 3'b010, lsuPkg::AtomicNone, 1'b0, stall);
  endtask

  task automatic buildTable();
    lsuPkg::xlenT b;
    b = lsuPkg::DtimBase;
    addRow(b + 'h10, 2'b01, 3'b010, 2'b00, 0, 0);             // Word round trip
    idle(0);
    addRow(b + 'h10, 2'b10, 3'b010, 2'b00, 0, 0);
    addRow(b + 'h30, 2'b01, 3'b010, 2'b00, 0, 0);             // Bytes at each offset
    addRow(b + 'h34, 2'b01, 3'b010, 2'b00, 0, 0);
    idle(0);
    addRow(b + 'h31, 2'b01, 3'b000, 2'b00, 0, 0);
    addRow(b + 'h32, 2'b01, 3'b000, 2'b00, 0, 0);
    addRow(b + 'h34, 2'b01, 3'b000, 2'b00, 0, 0);
    addRow(b + 'h37, 2'b01, 3'b000, 2'b00, 0, 0);
    idle(0);
    for (int o = 0; o < 8; o++) begin
      addRow(b + 'h30 + o, 2'b10, 3'b000, 2'b00, 0, 0);       // LB
      addRow(b + 'h30 + o, 2'b10, 3'b100, 2'b00, 0, 0);       // LBU
    end
    addRow(b + 'h40, 2'b01, 3'b010, 2'b00, 0, 0);             // Halfwords
    addRow(b + 'h44, 2'b01, 3'b010, 2'b00, 0, 0);
    idle(0);
    addRow(b + 'h42, 2'b01, 3'b001, 2'b00, 0, 0);
    addRow(b + 'h44, 2'b01, 3'b001, 2'b00, 0, 0);
    idle(0);
    addRow(b + 'h40, 2'b10, 3'b001, 2'b00, 0, 0);
    addRow(b + 'h42, 2'b10, 3'b001, 2'b00, 0, 0);
    addRow(b + 'h42, 2'b10, 3'b101, 2'b00, 0, 0);
    addRow(b + 'h44, 2'b10, 3'b001, 2'b00, 0, 0);
    addRow(b + 'h44, 2'b10, 3'b101, 2'b00, 0, 0);
    addRow(b + 'h40, 2'b10, 3'b010, 2'b00, 0, 0);
    addRow(b + 'h44, 2'b10, 3'b010, 2'b00, 0, 0);
    addRow(b + 'h50, 2'b01, 3'b010, 2'b00, 1, 0);             // Big-endian word
    idle(0);
    addRow(b + 'h50, 2'b10, 3'b010, 2'b00, 0, 0);
    addRow(b + 'h50, 2'b10, 3'b010, 2'b00, 1, 0);
    addRow(b + 'h52, 2'b01, 3'b001, 2'b00, 1, 0);
    idle(0);
    addRow(b + 'h52, 2'b10, 3'b001, 2'b00, 1, 0);
    addRow(b + 'h51, 2'b10, 3'b100, 2'b00, 1, 0);
    addRow(b + 'h60, 2'b01, 3'b010, 2'b00, 0, 0);             // Faults
    addRow(b + 'h61, 2'b01, 3'b001, 2'b00, 0, 0);
    addRow(b + 'h62, 2'b01, 3'b010, 2'b00, 0, 0);
    addRow(b + 'h63, 2'b10, 3'b001, 2'b00, 0, 0);
    addRow(32'h7000_0060, 2'b01, 3'b010, 2'b00, 0, 0);        // Same DTIM index as 0x60
    addRow(b + 'h400, 2'b10, 3'b010, 2'b00, 0, 0);
    addRow(b - 'h4, 2'b01, 3'b010, 2'b00, 0, 0);
    idle(0);
    addRow(b + 'h60, 2'b10, 3'b010, 2'b00, 0, 0);
    addRow(b + 'h70, 2'b01, 3'b010, 2'b00, 0, 0);             // LR/SC
    addRow(b + 'h78, 2'b01, 3'b010, 2'b00, 0, 0);
    idle(0);
    addRow(b + 'h70, 2'b10, 3'b010, lsuPkg::AtomicLr, 0, 0);
    addRow(b + 'h70, 2'b01, 3'b010, lsuPkg::AtomicSc, 0, 0);
    idle(0);
    addRow(b + 'h70, 2'b10, 3'b010, 2'b00, 0, 0);
    addRow(b + 'h70, 2'b01, 3'b010, lsuPkg::AtomicSc, 0, 0);
    idle(0);
    addRow(b + 'h70, 2'b10, 3'b010, 2'b00, 0, 0);
    addRow(b + 'h74, 2'b10, 3'b010, lsuPkg::AtomicLr, 0, 0);
    addRow(b + 'h78, 2'b01, 3'b010, lsuPkg::AtomicSc, 0, 0);
    idle(0);
    addRow(b + 'h78, 2'b10, 3'b010, 2'b00, 0, 0);
    addRow(b + 'h80, 2'b01, 3'b010, 2'b00, 0, 0);             // Stalls around a load
    idle(0);
    addRow(b + 'h80, 2'b10, 3'b010, 2'b00, 0, 0);
    idle(4);                        // Load held in M
    idle(3);                        // Load result held in W
    idle(0);
    idle(0);                        // Drain the pipeline
  endtask

  //////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////

  initial begin
    int total;
    rst = 1'b1;
    StallM = 1'b0;
    StallW = 1'b0;
    IEUAdrE = '0;
    CtrlM = '0;
    WriteDataM = '0;
    buildTable();
    total = 16;
    foreach (rows[i]) total += 1 + rows[i].stall;
    cycleLimit = total + 40;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      for (int s = 0; s <= rows[i].stall; s++) begin
        @(posedge clk);
        #1;
        IEUAdrE = rows[i].adr;
        CtrlM = (i > 0) ? rows[i-1].ctrl : '0;
        WriteDataM = (i > 0) ? rows[i-1].data : '0;
        StallM = (s < rows[i].stall);
        StallW = StallM;            // W stalls with M
        #4;
        if (i > 0) begin
          wordCheck("IEUAdrM", IEUAdrM, rows[i-1].adr);
          faultCheck({LoadMisalignedFaultM, StoreAmoMisalignedFaultM,
                      LoadAccessFaultM, StoreAmoAccessFaultM}, rows[i-1].expFault);
        end
        if (i > 1) begin
          if (rows[i-2].readValid) wordCheck("ReadDataW", ReadDataW, rows[i-2].expRead);
          squashCheck(SquashSCW, rows[i-2].expSquash);
        end
      end
    end
    if (i_lsu.i_lsuChecker.failCount == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      failRun("Assertion failures reported by the LSU checker");
    end
  end

endmodule

// ==== tests/lsu_checker.sv ====
/*
  LSU protocol checker
  Concurrent assertions bound into the load/store unit top level
*/

`timescale 1ns/1ps

module lsuChecker (
  input logic            clk,
  input logic            rst,
  input logic            StallW,
  input lsuPkg::lsuCtrlT CtrlM,
  input logic            DtimWrEnM,
  input logic            LoadMisalignedFaultM,
  input logic            StoreAmoMisalignedFaultM,
  input logic            LoadAccessFaultM,
  input logic            StoreAmoAccessFaultM,
  input logic            SquashSCW,
  input lsuPkg::xlenT    ReadDataW
);

  logic AnyFaultM;
  int   failCount = 0;                 // Failed assertions so far

  assign AnyFaultM = LoadMisalignedFaultM | StoreAmoMisalignedFaultM |
                     LoadAccessFaultM | StoreAmoAccessFaultM;

  ////////////////////////////////////////
  // Memory stage rules
  ////////////////////////////////////////

  // A faulting access must never reach the DTIM
  noWriteOnFault: assert property (@(posedge clk) disable iff (rst)
    DtimWrEnM |-> !AnyFaultM)
    else begin
      failCount++;
      $error("DTIM write enabled during a fault");
    end

  faultNeedsAccess: assert property (@(posedge clk) disable iff (rst)
    AnyFaultM |-> (CtrlM.memRw != 2'b00))  // Idle never faults
    else begin
      failCount++;
      $error("Fault raised with no access in the memory stage");
    end

  ////////////////////////////////////////
  // Writeback stage rules
  ////////////////////////////////////////

  squashAfterSc: assert property (@(posedge clk) disable iff (rst)
    $rose(SquashSCW) |-> $past(CtrlM.memRw[0] && CtrlM.atomic == lsuPkg::AtomicSc))
    else begin
      failCount++;
      $error("SquashSCW set without a preceding SC");
    end

  holdOnStall: assert property (@(posedge clk) disable iff (rst)
    StallW |=> $stable(ReadDataW))       // W register frozen
    else begin
      failCount++;
      $error("ReadDataW changed while StallW was high");
    end

endmodule

bind lsu lsuChecker i_lsuChecker (
  .clk, .rst, .StallW, .CtrlM, .DtimWrEnM,
  .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM,
  .LoadAccessFaultM, .StoreAmoAccessFaultM,
  .SquashSCW, .ReadDataW
);

// ==== hdl/lsu.sv ====
/*
  Load/store unit top level
  Address stage, store and load formatting, LR/SC reservation and DTIM
*/

`timescale 1ns/1ps

module lsu (
  input  logic           clk,
  input  logic           rst,
  input  logic           StallM,
  input  logic           StallW,
  input  lsuPkg::xlenT    IEUAdrE,                   // Execute stage address
  input  lsuPkg::lsuCtrlT CtrlM,                     // Memory stage control
  input  lsuPkg::xlenT    WriteDataM,                // Store data from the IEU
  output lsuPkg::xlenT    IEUAdrM,
  output logic           LoadMisalignedFaultM,
  output logic           StoreAmoMisalignedFaultM,
  output logic           LoadAccessFaultM,
  output logic           StoreAmoAccessFaultM,
  output lsuPkg::xlenT    ReadDataW,                 // Formatted load result
  output logic           SquashSCW                  // Failed SC, result is 1
);

  lsuPkg::xlenT     AdrM;
  lsuPkg::dtimAdrT  RdIdxE;
  logic             AccessOkM;                       // No fault and inside DTIM
  lsuPkg::xlenT     WrDataM;
  lsuPkg::byteMaskT ByteMaskM;
  logic             ScPassM;
  logic             DtimWrEnM;
  lsuPkg::xlenT     RdWordM;                         // Raw DTIM word

  assign IEUAdrM = AdrM;

  ////////////////////////////////////////
  // Address stage and fault checks
  ////////////////////////////////////////

  lsuAddrStage i_addrStage (
    .clk, .rst, .StallM, .IEUAdrE, .CtrlM,
    .AdrM, .RdIdxE, .AccessOkM,
    .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM,
    .LoadAccessFaultM, .StoreAmoAccessFaultM
  );

  ////////////////////////////////////////
  // Store path
  ////////////////////////////////////////

  storeFormat i_storeFormat (
    .CtrlM, .AdrLowM(AdrM[1:0]), .WriteDataM, .WrDataM, .ByteMaskM
  );

  reservation i_reservation (
    .clk, .rst, .StallW, .CtrlM, .AdrM, .AccessOkM, .ScPassM, .SquashSCW
  );

  // Write only for a clean access; a failed SC leaves memory alone
  assign DtimWrEnM = CtrlM.memRw[0] & AccessOkM & ~StallW &
                     ((CtrlM.atomic != lsuPkg::AtomicSc) | ScPassM);

  dtim i_dtim (
    .clk,
    .RdEn     (~StallM),                             // Read register follows the M stage
    .RdIdxE,
    .WrEn     (DtimWrEnM),
    .WrIdxM   (AdrM[lsuPkg::DtimAdrBits+1:2]),
    .ByteMaskM,
    .WrDataM,
    .RdWordM
  );

  ////////////////////////////////////////
  // Load path
  ////////////////////////////////////////

  loadFormat i_loadFormat (
    .clk, .rst, .StallW, .CtrlM, .AdrLowM(AdrM[1:0]), .RdWordM, .ReadDataW
  );

endmodule

// ==== hdl/reservation.sv ====
/*
  LR/SC reservation
  Tracks one reserved word and decides whether a store-conditional passes
*/

`timescale 1ns/1ps

module reservation (
  input  logic            clk,
  input  logic            rst,
  input  logic            StallW,
  input  lsuPkg::lsuCtrlT CtrlM,
  input  lsuPkg::xlenT    AdrM,
  input  logic            AccessOkM,
  output logic            ScPassM,                  // SC may write memory
  output logic            SquashSCW
);

  logic                      ResValid;
  logic [lsuPkg::Xlen-1:2]   ResAdr;                // Reserved word address
  logic                      IsLrM;
  logic                      IsScM;

  assign IsLrM = CtrlM.memRw[1] & (CtrlM.atomic == lsuPkg::AtomicLr);
  assign IsScM = CtrlM.memRw[0] & (CtrlM.atomic == lsuPkg::AtomicSc);

  assign ScPassM = IsScM & ResValid & (ResAdr == AdrM[lsuPkg::Xlen-1:2]);

  ////////////////////////////////////////
  // Reservation state
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ResValid <= 1'b0;
    end else if (!StallW) begin
      if (IsLrM && AccessOkM) ResValid <= 1'b1;     // LR sets it
      else if (IsScM)         ResValid <= 1'b0;     // Any SC consumes it
    end
  end

  always_ff @(posedge clk) begin
    if (IsLrM && AccessOkM && !StallW) begin
      ResAdr <= AdrM[lsuPkg::Xlen-1:2];
    end
  end

  // Registered with the load result, 1 means SC failed
  always_ff @(posedge clk) begin
    if (rst) begin
      SquashSCW <= 1'b0;
    end else if (!StallW) begin
      SquashSCW <= IsScM & ~ScPassM;
    end
  end

endmodule

// ==== hdl/loadFormat.sv ====
/*
  Load data formatter and M-to-W read data register
  Endian swap, subword select, sign or zero extension
*/

`timescale 1ns/1ps

module loadFormat (
  input  logic            clk,
  input  logic            rst,
  input  logic            StallW,
  input  lsuPkg::lsuCtrlT CtrlM,
  input  logic [1:0]      AdrLowM,                  // Byte offset in the word
  input  lsuPkg::xlenT    RdWordM,                  // Raw word from DTIM
  output lsuPkg::xlenT    ReadDataW
);

  lsuPkg::xlenT WordM;                              // Word in little-endian order
  logic [1:0]   SwizzleM;                           // Offset correction for big endian
  logic [1:0]   OffM;
  logic [7:0]   ByteM;
  logic [15:0]  HalfM;
  logic         UnsignedM;
  lsuPkg::xlenT LoadDataM;

  ////////////////////////////////////////
  // Endian correction
  ////////////////////////////////////////

  assign WordM = CtrlM.bigEndian ? lsuPkg::byteSwap(RdWordM) : RdWordM;

  // The full swap mirrors the lanes, so the offset mirrors too
  always_comb begin
    SwizzleM = 2'b00;
    if (CtrlM.bigEndian) begin
      case (CtrlM.funct3[1:0])
        lsuPkg::SizeByte: SwizzleM = 2'b11;
        lsuPkg::SizeHalf: SwizzleM = 2'b10;
        default:          SwizzleM = 2'b00;         // Word needs no correction
      endcase
    end
  end

  assign OffM = AdrLowM ^ SwizzleM;

  ////////////////////////////////////////
  // Subword select and extension
  ////////////////////////////////////////

  assign ByteM     = WordM[{OffM, 3'b000} +: 8];
  assign HalfM     = WordM[{OffM[1], 4'b0000} +: 16];
  assign UnsignedM = CtrlM.funct3[2];               // LBU and LHU

  always_comb begin
    case (CtrlM.funct3[1:0])
      lsuPkg::SizeByte: LoadDataM = {{24{ByteM[7] & ~UnsignedM}}, ByteM};
      lsuPkg::SizeHalf: LoadDataM = {{16{HalfM[15] & ~UnsignedM}}, HalfM};
      default:          LoadDataM = WordM;
    endcase
  end

  ////////////////////////////////////////
  // M to W register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ReadDataW <= '0;
    end else if (CtrlM.memRw[1] && !StallW) begin
      ReadDataW <= LoadDataM;                       // Only loads update it
    end
  end

endmodule

// ==== hdl/storeFormat.sv ====
/*
  Store data formatter
  Replicates subword data, builds byte lane mask, big-endian swap
*/

`timescale 1ns/1ps

module storeFormat (
  input  lsuPkg::lsuCtrlT  CtrlM,
  input  logic [1:0]       AdrLowM,                 // Byte offset in the word
  input  lsuPkg::xlenT     WriteDataM,
  output lsuPkg::xlenT     WrDataM,
  output lsuPkg::byteMaskT ByteMaskM
);

  lsuPkg::xlenT ReplDataM;                          // Little-endian replicated data

  ////////////////////////////////////////
  // Subword replication
  ////////////////////////////////////////

  // Every lane carries the subword, the mask picks the right one
  always_comb begin
    case (CtrlM.funct3[1:0])
      lsuPkg::SizeByte: ReplDataM = {4{WriteDataM[7:0]}};
      lsuPkg::SizeHalf: ReplDataM = {2{WriteDataM[15:0]}};
      default:          ReplDataM = WriteDataM;
    endcase
  end

  ////////////////////////////////////////
  // Byte mask
  ////////////////////////////////////////

  always_comb begin
    case (CtrlM.funct3[1:0])
      lsuPkg::SizeByte: begin
        ByteMaskM = lsuPkg::byteMaskT'(4'b0001 << AdrLowM);
      end
      lsuPkg::SizeHalf: begin
        // Low address bit is a misaligned fault, only the half select matters
        ByteMaskM = AdrLowM[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        ByteMaskM = '1;                              // Full word
      end
    endcase
  end

  ////////////////////////////////////////
  // Endian swap
  ////////////////////////////////////////

  // Memory holds big-endian words when the access asks for it
  // Byte stores are unaffected since all lanes match
  assign WrDataM = CtrlM.bigEndian ? lsuPkg::byteSwap(ReplDataM) : ReplDataM;

endmodule

// ==== hdl/lsuAddrStage.sv ====
/*
  Execute-to-memory address register
  DTIM read index plus misaligned and access fault detection
*/

`timescale 1ns/1ps

module lsuAddrStage (
  input  logic            clk,
  input  logic            rst,
  input  logic            StallM,
  input  lsuPkg::xlenT    IEUAdrE,
  input  lsuPkg::lsuCtrlT CtrlM,
  output lsuPkg::xlenT    AdrM,
  output lsuPkg::dtimAdrT RdIdxE,                    // Word index for the early DTIM read
  output logic            AccessOkM,
  output logic            LoadMisalignedFaultM,
  output logic            StoreAmoMisalignedFaultM,
  output logic            LoadAccessFaultM,
  output logic            StoreAmoAccessFaultM
);

  logic         MisalignedM;
  logic         InRangeM;
  lsuPkg::xlenT OffsetM;                             // Distance from DTIM base

  ////////////////////////////////////////
  // E to M address register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      AdrM <= '0;
    end else if (!StallM) begin
      AdrM <= IEUAdrE;                               // Holds while M is stalled
    end
  end

  // Read starts in E so data is ready in M
  assign RdIdxE = IEUAdrE[lsuPkg::DtimAdrBits+1:2];

  ////////////////////////////////////////
  // Fault checks
  ////////////////////////////////////////

  always_comb begin
    case (CtrlM.funct3[1:0])
      lsuPkg::SizeByte: MisalignedM = 1'b0;
      lsuPkg::SizeHalf: MisalignedM = AdrM[0];
      default:          MisalignedM = |AdrM[1:0];     // Word, and the unused code
    endcase
  end

  // Wraps below base, so one unsigned compare covers both bounds
  assign OffsetM  = AdrM - lsuPkg::DtimBase;
  assign InRangeM = OffsetM < lsuPkg::xlenT'(lsuPkg::DtimWords * lsuPkg::ByteLanes);

  assign AccessOkM = InRangeM & ~MisalignedM;

  assign LoadMisalignedFaultM     = CtrlM.memRw[1] & MisalignedM;
  assign StoreAmoMisalignedFaultM = CtrlM.memRw[0] & MisalignedM;

  // Misalignment takes priority over the range check
  assign LoadAccessFaultM     = CtrlM.memRw[1] & ~MisalignedM & ~InRangeM;
  assign StoreAmoAccessFaultM = CtrlM.memRw[0] & ~MisalignedM & ~InRangeM;

endmodule

// ==== hdl/dtim.sv ====
/*
  Data tightly integrated memory
  Word wide, byte lane writes, registered read
*/

`timescale 1ns/1ps

module dtim (
  input  logic             clk,
  input  logic             RdEn,                     // Low holds the read register
  input  lsuPkg::dtimAdrT  RdIdxE,
  input  logic             WrEn,
  input  lsuPkg::dtimAdrT  WrIdxM,
  input  lsuPkg::byteMaskT ByteMaskM,
  input  lsuPkg::xlenT     WrDataM,
  output lsuPkg::xlenT     RdWordM
);

  lsuPkg::xlenT Mem [lsuPkg::DtimWords];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (WrEn) begin
      for (int i = 0; i < lsuPkg::ByteLanes; i++) begin
        if (ByteMaskM[i]) begin
          Mem[WrIdxM][8*i +: 8] <= WrDataM[8*i +: 8];  // Untouched lanes keep old data
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Same edge read and write returns the old word
  always_ff @(posedge clk) begin
    if (RdEn) begin
      RdWordM <= Mem[RdIdxE];
    end
  end

endmodule

// ==== hdl/lsuPkg.sv ====
/*
  Load/store unit shared definitions
  Widths, access codes, control struct, DTIM geometry and the byte swapper
*/

package lsuPkg;

  ////////////////////////////////////////
  // Data path widths
  ////////////////////////////////////////

  localparam int Xlen      = 32;              // Data and address width
  localparam int ByteLanes = Xlen / 8;        // Bytes per word

  typedef logic [Xlen-1:0]      xlenT;        // Data or address word
  typedef logic [ByteLanes-1:0] byteMaskT;    // One write enable per byte lane

  ////////////////////////////////////////
  // Access control codes
  ////////////////////////////////////////

  // Bit 1 read, bit 0 write
  typedef logic [1:0] memRwT;

  // Low two bits size, top bit marks an unsigned load
  typedef logic [2:0] funct3T;

  localparam logic [1:0] SizeByte = 2'b00;
  localparam logic [1:0] SizeHalf = 2'b01;
  localparam logic [1:0] SizeWord = 2'b10;

  typedef logic [1:0] atomicT;

  localparam atomicT AtomicNone = 2'b00;     // Plain load or store
  localparam atomicT AtomicLr   = 2'b01;     // Load reserved
  localparam atomicT AtomicSc   = 2'b10;     // Store conditional

  // All memory-stage control in one word
  typedef struct packed {
    memRwT  memRw;
    funct3T funct3;
    atomicT atomic;
    logic   bigEndian;                       // Swap byte order on this access
  } lsuCtrlT;

  ////////////////////////////////////////
  // DTIM geometry
  ////////////////////////////////////////

  localparam xlenT DtimBase    = 32'h8000_0000;
  localparam int   DtimWords   = 256;
  localparam int   DtimAdrBits = $clog2(DtimWords);

  typedef logic [DtimAdrBits-1:0] dtimAdrT;  // Word index into DTIM

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Reverse the byte order of a word
  function automatic xlenT byteSwap(input xlenT Din);
    xlenT Dout;
    for (int i = 0; i < ByteLanes; i++) begin
      Dout[8*i +: 8] = Din[8*(ByteLanes-1-i) +: 8];  // Lane i takes the mirror lane
    end
    return Dout;
  endfunction

endpackage
